/* build.f */
lsdom_bus_pkg.sv
lsdom_map_pkg.sv
lsdom_arbiter.sv
lsdom_decoder.sv
lsdom_mem.sv
lsdom_syscfg.sv
lsdom_fabric.sv
lsdom_fabric_asserts.sv
lsdom_fabric_checker.sv
lsdom_fabric_tb.sv

/* lsdom_fabric_tb.sv */
`timescale 1ns/1ps

module lsdom_fabric_tb;

    localparam int NUM_MSTS    = 3;
    localparam int MEM_WORDS   = 1024;
    localparam int NUM_SCRATCH = 4;
    localparam int TIMEOUT     = 200;   // Cycles per wait
    localparam int HS_WORDS    = 1024;

    logic                    seq;
    logic                    rst_n;
    logic                    pause;
    logic [NUM_MSTS-1:0]     mst_req;
    lsdom_bus_pkg::bus_req_t mst_req_data [NUM_MSTS];
    logic [NUM_MSTS-1:0]     mst_done;
    lsdom_bus_pkg::bus_rsp_t mst_rsp;
    logic                    hsdom_sel;
    lsdom_bus_pkg::bus_req_t hsdom_req;
    logic                    hsdom_done;
    lsdom_bus_pkg::bus_rsp_t hsdom_rsp;

    integer seed = 32'h413e3bd1;

    lsdom_bus_pkg::data_t sh_mem [MEM_WORDS];
    lsdom_bus_pkg::data_t sh_scratch [NUM_SCRATCH];
    lsdom_bus_pkg::data_t sh_hs [HS_WORDS];
    lsdom_bus_pkg::data_t bridge_mem [HS_WORDS];   // Responder's own store

    initial begin
        seq = 1'b0;
        forever begin
            #50 seq = ~seq;
        end
    end

    lsdom_fabric #(
        .NUM_MSTS    (NUM_MSTS),
        .MEM_WORDS   (MEM_WORDS),
        .NUM_SCRATCH (NUM_SCRATCH)
    ) dut_i (
        .seq          (seq),
        .rst_n        (rst_n),
        .pause        (pause),
        .mst_req      (mst_req),
        .mst_req_data (mst_req_data),
        .mst_done     (mst_done),
        .mst_rsp      (mst_rsp),
        .hsdom_sel    (hsdom_sel),
        .hsdom_req    (hsdom_req),
        .hsdom_done   (hsdom_done),
        .hsdom_rsp    (hsdom_rsp)
    );

    lsdom_fabric_checker #(
        .NUM_MSTS (NUM_MSTS)
    ) chk_i (
        .seq      (seq),
        .rst_n    (rst_n),
        .mst_done (mst_done),
        .mst_rsp  (mst_rsp)
    );

    function automatic lsdom_bus_pkg::data_t fill_word(input int i);
        return lsdom_bus_pkg::data_t'(i) * 32'h9e37_79b1 + 32'h5a5a_0000;
    endfunction

    function automatic lsdom_bus_pkg::data_t apply_strobes(input lsdom_bus_pkg::data_t old_word,
                                                           input lsdom_bus_pkg::data_t new_word,
                                                           input lsdom_bus_pkg::strb_t strb);
        lsdom_bus_pkg::data_t merged;
        merged = old_word;
        for (int b = 0; b < lsdom_bus_pkg::STRB_WIDTH; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Expected response from the shadow model, which it also updates
    function automatic lsdom_bus_pkg::bus_rsp_t expect_rsp(input lsdom_bus_pkg::bus_req_t req);
        lsdom_bus_pkg::bus_rsp_t rsp;
        int idx;
        rsp.data = '0;
        rsp.resp = lsdom_bus_pkg::resp_okay;
        if (req.addr >= lsdom_map_pkg::hsdom_boundary) begin
            idx = int'(req.addr[11:2]);   // Bridge store aliases every 4 KiB
            if (req.wr) begin
                sh_hs[idx] = apply_strobes(sh_hs[idx], req.data, req.strb);
            end else begin
                rsp.data = sh_hs[idx];
            end
        end else if (req.addr >= lsdom_map_pkg::lpmem_base &&
                     req.addr < lsdom_map_pkg::lpmem_base + lsdom_map_pkg::lpmem_size) begin
            idx = int'((req.addr - lsdom_map_pkg::lpmem_base) >> 2);
            if (req.wr) begin
                sh_mem[idx] = apply_strobes(sh_mem[idx], req.data, req.strb);
            end else begin
                rsp.data = sh_mem[idx];
            end
        end else if (req.addr >= lsdom_map_pkg::syscfg_base &&
                     req.addr < lsdom_map_pkg::syscfg_base + lsdom_map_pkg::syscfg_size) begin
            idx = int'((req.addr - lsdom_map_pkg::syscfg_base) >> 2);
            if (idx == 0) begin
                if (req.wr) begin
                    rsp.resp = lsdom_bus_pkg::resp_slverr;
                end else begin
                    rsp.data = lsdom_map_pkg::syscfg_id_value;
                end
            end else if (idx <= NUM_SCRATCH) begin
                if (req.wr) begin
                    sh_scratch[idx-1] = apply_strobes(sh_scratch[idx-1], req.data, req.strb);
                end else begin
                    rsp.data = sh_scratch[idx-1];
                end
            end
        end else begin
            rsp.resp = lsdom_bus_pkg::resp_decerr;   // Hole in the map
        end
        return rsp;
    endfunction

    function automatic lsdom_bus_pkg::addr_t region_edge(input int k);
        case (k)
            0: return lsdom_map_pkg::lpmem_base;
            1: return lsdom_map_pkg::lpmem_base + lsdom_map_pkg::lpmem_size - 4;
            2: return lsdom_map_pkg::syscfg_base + 4;                 // First scratch
            3: return lsdom_map_pkg::syscfg_base + 4 * NUM_SCRATCH;   // Last scratch
            4: return lsdom_map_pkg::hsdom_boundary;
            default: return 32'hffff_fffc;
        endcase
    endfunction

    // Entered and left 1 ns after a rising edge
    task automatic run_access(input int m, input logic wr, input lsdom_bus_pkg::addr_t addr,
                              input lsdom_bus_pkg::data_t data, input lsdom_bus_pkg::strb_t strb);
        lsdom_bus_pkg::bus_req_t req;
        int   waited;
        logic got;
        req.wr   = wr;
        req.addr = addr;
        req.data = data;
        req.strb = strb;
        chk_i.push_expect(m, expect_rsp(req));
        mst_req_data[m] = req;
        mst_req[m]      = 1'b1;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < TIMEOUT) begin
            @(posedge seq);
            waited++;
            got = mst_done[m];
        end
        if (!got) begin
            chk_i.note_timeout($sformatf("master %0d saw no done within %0d cycles for address %h",
                                         m, TIMEOUT, addr));
        end
        #1;
        mst_req[m] = 1'b0;
    endtask

    // Write then read back, rotating over memory, scratch and bridge
    task automatic contend(input int m, input int rounds);
        lsdom_bus_pkg::addr_t a;
        lsdom_bus_pkg::data_t d;
        for (int r = 0; r < rounds; r++) begin
            case (r % 3)
                0: a = 32'h0000_0800 + lsdom_bus_pkg::addr_t'(m * 64 + r * 4);
                1: a = lsdom_map_pkg::syscfg_base + lsdom_bus_pkg::addr_t'(4 * (m + 1));
                default: a = 32'h9000_0000 + lsdom_bus_pkg::addr_t'(m * 64 + r * 4);
            endcase
            d = $random(seed);
            run_access(m, 1'b1, a, d, 4'hf);
            run_access(m, 1'b0, a, '0, 4'hf);
        end
    endtask

    // Bridge responder with 0 to 5 cycles of extra latency
    initial begin
        lsdom_bus_pkg::bus_req_t breq;
        int   delay;
        int   idx;
        logic known;
        forever begin
            @(posedge seq);
            if (rst_n && hsdom_sel) begin
                breq  = hsdom_req;
                delay = int'($unsigned($random(seed)) % 6);
                known = 1'b0;
                for (int m = 0; m < NUM_MSTS; m++) begin
                    if (mst_req[m] && mst_req_data[m] == breq) begin
                        known = 1'b1;
                    end
                end
                if (!known) begin
                    chk_i.note_mismatch($sformatf("bridge request for %h matches no master",
                                                  breq.addr));
                end
                if (breq.addr < lsdom_map_pkg::hsdom_boundary) begin
                    chk_i.note_mismatch($sformatf("bridge selected for address %h below the boundary",
                                                  breq.addr));
                end
                idx = int'(breq.addr[11:2]);
                repeat (delay) @(posedge seq);
                #1;
                hsdom_done     = 1'b1;
                hsdom_rsp.resp = lsdom_bus_pkg::resp_okay;
                if (breq.wr) begin
                    bridge_mem[idx] = apply_strobes(bridge_mem[idx], breq.data, breq.strb);
                    hsdom_rsp.data  = '0;
                end else begin
                    hsdom_rsp.data = bridge_mem[idx];
                end
                @(posedge seq);
                #1;
                hsdom_done = 1'b0;
            end
        end
    end

    initial begin
        lsdom_bus_pkg::addr_t a;
        int total;
        rst_n      = 1'b0;
        pause      = 1'b0;
        mst_req    = '0;
        hsdom_done = 1'b0;
        hsdom_rsp  = '0;
        for (int m = 0; m < NUM_MSTS; m++) begin
            mst_req_data[m] = '0;
        end
        for (int i = 0; i < HS_WORDS; i++) begin
            sh_hs[i]      = fill_word(i);
            bridge_mem[i] = fill_word(i);
        end
        for (int i = 0; i < NUM_SCRATCH; i++) begin
            sh_scratch[i] = '0;
        end
        repeat (2) @(posedge seq);
        #1;
        rst_n = 1'b1;

        for (int m = 0; m < NUM_MSTS; m++) begin   // Region edges with a full then a partial write
            for (int k = 0; k < 6; k++) begin
                a = region_edge(k);
                run_access(m, 1'b1, a, $random(seed), 4'hf);
                run_access(m, 1'b1, a, $random(seed), lsdom_bus_pkg::strb_t'($random(seed)));
                run_access(m, 1'b0, a, '0, 4'hf);
            end
        end

        run_access(0, 1'b1, lsdom_map_pkg::syscfg_base, 32'hdead_beef, 4'hf);
        run_access(1, 1'b0, lsdom_map_pkg::syscfg_base, '0, 4'hf);
        run_access(2, 1'b0, lsdom_map_pkg::syscfg_base + lsdom_map_pkg::syscfg_size - 4, '0, 4'hf);

        a = lsdom_map_pkg::lpmem_base + lsdom_map_pkg::lpmem_size;   // Holes below the bridge
        run_access(1, 1'b1, a, 32'h1234_5678, 4'hf);
        run_access(1, 1'b0, a, '0, 4'hf);
        run_access(2, 1'b0, lsdom_map_pkg::syscfg_base + lsdom_map_pkg::syscfg_size, '0, 4'hf);
        run_access(0, 1'b0, lsdom_map_pkg::hsdom_boundary - 4, '0, 4'hf);

        chk_i.start_fairness();
        fork
            contend(0, 12);
            contend(1, 12);
            contend(2, 12);
        join
        chk_i.stop_fairness();

        pause = 1'b1;
        fork
            run_access(0, 1'b0, region_edge(0), '0, 4'hf);
            run_access(1, 1'b0, region_edge(2), '0, 4'hf);
            run_access(2, 1'b0, region_edge(4), '0, 4'hf);
            begin
                repeat (20) begin
                    @(posedge seq);
                    if (mst_done !== '0) begin
                        chk_i.note_fault("A master completed while pause was high");
                    end
                end
                #1;
                pause = 1'b0;
            end
        join

        for (int i = 0; i < 8; i++) begin
            a = lsdom_map_pkg::hsdom_boundary |
                (lsdom_bus_pkg::addr_t'($random(seed)) & 32'h7fff_fffc);
            run_access(i % NUM_MSTS, 1'b0, a, '0, 4'hf);
            run_access(i % NUM_MSTS, 1'b1, a, $random(seed), 4'hf);
            run_access((i + 1) % NUM_MSTS, 1'b0, a, '0, 4'hf);
        end

        repeat (5) @(posedge seq);
        if (chk_i.pending_count() != 0) begin
            chk_i.note_fault($sformatf("%0d expected responses never arrived",
                                       chk_i.pending_count()));
        end
        total = chk_i.mismatch_count + chk_i.timeout_count + chk_i.fault_count +
                dut_i.asserts_i.assert_failures;
        $display("Errors: %0d mismatches, %0d timeouts, %0d other, %0d assertion failures",
                 chk_i.mismatch_count, chk_i.timeout_count, chk_i.fault_count,
                 dut_i.asserts_i.assert_failures);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* lsdom_fabric_checker.sv */
`timescale 1ns/1ps

module lsdom_fabric_checker #(
    parameter int NUM_MSTS = 3
) (
    input logic                    seq,
    input logic                    rst_n,
    input logic [NUM_MSTS-1:0]     mst_done,
    input lsdom_bus_pkg::bus_rsp_t mst_rsp
);

    typedef struct packed {
        logic [7:0]              mst;
        lsdom_bus_pkg::bus_rsp_t rsp;
    } expect_t;

    expect_t exp_q [$];   // In issue order, tagged by master
    int      done_count [NUM_MSTS];
    int      fair_base [NUM_MSTS];
    logic    fair_on        = 1'b0;
    int      mismatch_count = 0;
    int      timeout_count  = 0;
    int      fault_count    = 0;

    task automatic push_expect(input int m, input lsdom_bus_pkg::bus_rsp_t rsp);
        expect_t e;
        e.mst = 8'(m);
        e.rsp = rsp;
        exp_q.push_back(e);
    endtask

    task automatic note_mismatch(input string what);
        mismatch_count++;
        $display("Mismatch at %0t: %s", $time, what);
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic note_fault(input string what);
        fault_count++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic start_fairness();
        for (int m = 0; m < NUM_MSTS; m++) begin
            fair_base[m] = done_count[m];
        end
        fair_on = 1'b1;
    endtask

    task automatic stop_fairness();
        fair_on = 1'b0;
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic check_done(input int m);
        int pos;
        int lo;
        int hi;
        int n;
        pos = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (pos < 0 && exp_q[i].mst == 8'(m)) begin
                pos = i;
            end
        end
        done_count[m]++;
        if (pos < 0) begin
            note_fault($sformatf("master %0d got a done pulse with nothing outstanding", m));
        end else begin
            if (mst_rsp !== exp_q[pos].rsp) begin
                note_mismatch($sformatf("master %0d expected data %h resp %0d, got data %h resp %0d",
                                        m, exp_q[pos].rsp.data, exp_q[pos].rsp.resp,
                                        mst_rsp.data, mst_rsp.resp));
            end
            exp_q.delete(pos);
        end
        if (fair_on) begin
            lo = done_count[0] - fair_base[0];
            hi = lo;
            for (int k = 1; k < NUM_MSTS; k++) begin
                n  = done_count[k] - fair_base[k];
                lo = (n < lo) ? n : lo;
                hi = (n > hi) ? n : hi;
            end
            if (hi - lo > 1) begin
                note_mismatch($sformatf("completion counts drift apart by %0d", hi - lo));
            end
        end
    endtask

    always @(posedge seq) begin
        if (rst_n) begin
            for (int m = 0; m < NUM_MSTS; m++) begin
                if (mst_done[m]) begin
                    check_done(m);
                end
            end
        end
    end

endmodule

/* lsdom_fabric_asserts.sv */
`timescale 1ns/1ps

module lsdom_fabric_asserts #(
    parameter int  NUM_MSTS = 3,
    localparam int IDX_W    = (NUM_MSTS > 1) ? $clog2(NUM_MSTS) : 1
) (
    input logic                seq,
    input logic                rst_n,
    input logic                pause,
    input logic                gnt_valid,
    input logic [IDX_W-1:0]    gnt_idx,
    input logic                mem_sel,
    input logic                cfg_sel,
    input logic                hsdom_sel,
    input logic [NUM_MSTS-1:0] mst_done
);

    int assert_failures = 0;

    grant_held: assert property (@(posedge seq) disable iff (!rst_n)
        (gnt_valid && $past(gnt_valid)) |-> (gnt_idx == $past(gnt_idx)))
        else begin
            assert_failures++;
            $error("grant index changed while the bus was owned");
        end

    one_select: assert property (@(posedge seq) disable iff (!rst_n)
        $onehot0({mem_sel, cfg_sel, hsdom_sel}))
        else begin
            assert_failures++;
            $error("more than one slave selected");
        end

    one_done: assert property (@(posedge seq) disable iff (!rst_n)
        $onehot0(mst_done))
        else begin
            assert_failures++;
            $error("done pulse reached more than one master");
        end

    paused_grant: assert property (@(posedge seq) disable iff (!rst_n)
        $rose(gnt_valid) |-> !$past(pause))
        else begin
            assert_failures++;
            $error("grant started while pause was high");
        end

endmodule

bind lsdom_fabric lsdom_fabric_asserts #(
    .NUM_MSTS (NUM_MSTS)
) asserts_i (
    .seq       (seq),
    .rst_n     (rst_n),
    .pause     (pause),
    .gnt_valid (gnt_valid),
    .gnt_idx   (gnt_idx),
    .mem_sel   (mem_sel),
    .cfg_sel   (cfg_sel),
    .hsdom_sel (hsdom_sel),
    .mst_done  (mst_done)
);

/* lsdom_fabric.sv */
`timescale 1ns/1ps

module lsdom_fabric #(
    parameter int  NUM_MSTS    = 3,
    parameter int  MEM_WORDS   = 1024,
    parameter int  NUM_SCRATCH = 4,
    localparam int IDX_W       = (NUM_MSTS > 1) ? $clog2(NUM_MSTS) : 1
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    pause,
    input  logic [NUM_MSTS-1:0]     mst_req,
    input  lsdom_bus_pkg::bus_req_t mst_req_data [NUM_MSTS],
    output logic [NUM_MSTS-1:0]     mst_done,
    output lsdom_bus_pkg::bus_rsp_t mst_rsp,
    output logic                    hsdom_sel,
    output lsdom_bus_pkg::bus_req_t hsdom_req,
    input  logic                    hsdom_done,
    input  lsdom_bus_pkg::bus_rsp_t hsdom_rsp
);

    logic                    gnt_valid;
    logic [IDX_W-1:0]        gnt_idx;
    lsdom_bus_pkg::bus_req_t gnt_req;
    logic                    bus_done;
    lsdom_bus_pkg::bus_req_t slv_req;
    logic                    mem_sel;
    logic                    mem_done;
    lsdom_bus_pkg::bus_rsp_t mem_rsp;
    logic                    cfg_sel;
    logic                    cfg_done;
    lsdom_bus_pkg::bus_rsp_t cfg_rsp;

    assign hsdom_req = slv_req;   // Bridge sees the address unchanged

    lsdom_arbiter #(
        .NUM_MSTS (NUM_MSTS)
    ) u_arbiter (
        .seq          (seq),
        .rst_n        (rst_n),
        .pause        (pause),
        .mst_req      (mst_req),
        .mst_req_data (mst_req_data),
        .bus_done     (bus_done),
        .gnt_valid    (gnt_valid),
        .gnt_idx      (gnt_idx),
        .gnt_req      (gnt_req)
    );

    lsdom_decoder #(
        .NUM_MSTS (NUM_MSTS)
    ) u_decoder (
        .seq        (seq),
        .rst_n      (rst_n),
        .gnt_valid  (gnt_valid),
        .gnt_idx    (gnt_idx),
        .gnt_req    (gnt_req),
        .mem_done   (mem_done),
        .mem_rsp    (mem_rsp),
        .cfg_done   (cfg_done),
        .cfg_rsp    (cfg_rsp),
        .hsdom_done (hsdom_done),
        .hsdom_rsp  (hsdom_rsp),
        .mem_sel    (mem_sel),
        .cfg_sel    (cfg_sel),
        .hsdom_sel  (hsdom_sel),
        .slv_req    (slv_req),
        .bus_done   (bus_done),
        .mst_done   (mst_done),
        .mst_rsp    (mst_rsp)
    );

    lsdom_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .seq   (seq),
        .rst_n (rst_n),
        .sel   (mem_sel),
        .req   (slv_req),
        .done  (mem_done),
        .rsp   (mem_rsp)
    );

    lsdom_syscfg #(
        .NUM_SCRATCH (NUM_SCRATCH)
    ) u_syscfg (
        .seq   (seq),
        .rst_n (rst_n),
        .sel   (cfg_sel),
        .req   (slv_req),
        .done  (cfg_done),
        .rsp   (cfg_rsp)
    );

endmodule

/* lsdom_syscfg.sv */
`timescale 1ns/1ps

module lsdom_syscfg #(
    parameter int  NUM_SCRATCH = 4,
    localparam int WORD_W      = $clog2(lsdom_map_pkg::syscfg_size / 4)
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    sel,
    input  lsdom_bus_pkg::bus_req_t req,
    output logic                    done,
    output lsdom_bus_pkg::bus_rsp_t rsp
);

    lsdom_bus_pkg::data_t    scratch [NUM_SCRATCH];
    lsdom_bus_pkg::addr_t    offset;
    logic [WORD_W-1:0]       word;
    logic                    is_scratch;
    int                      slot;
    lsdom_bus_pkg::bus_rsp_t rsp_next;

    assign offset     = req.addr - lsdom_map_pkg::syscfg_base;
    assign word       = offset[WORD_W+1:2];
    assign is_scratch = (word >= 1) && (int'(word) <= NUM_SCRATCH);
    assign slot       = int'(word) - 1;   // Scratch follows the ID word

    always_comb begin
        rsp_next.data = '0;
        rsp_next.resp = lsdom_bus_pkg::resp_okay;
        if (word == '0) begin
            if (req.wr) begin
                rsp_next.resp = lsdom_bus_pkg::resp_slverr;   // ID is read-only
            end else begin
                rsp_next.data = lsdom_map_pkg::syscfg_id_value;
            end
        end else if (is_scratch && !req.wr) begin
            rsp_next.data = scratch[slot];
        end
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else if (sel && req.wr && is_scratch) begin
            for (int b = 0; b < lsdom_bus_pkg::STRB_WIDTH; b++) begin
                if (req.strb[b]) begin
                    scratch[slot][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (sel) begin
            rsp <= rsp_next;
        end
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= sel;
        end
    end

endmodule

/* lsdom_mem.sv */
`timescale 1ns/1ps

module lsdom_mem #(
    parameter int  MEM_WORDS = 1024,
    localparam int WORD_W    = $clog2(MEM_WORDS)
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    sel,
    input  lsdom_bus_pkg::bus_req_t req,
    output logic                    done,
    output lsdom_bus_pkg::bus_rsp_t rsp
);

    lsdom_bus_pkg::data_t mem [MEM_WORDS];
    lsdom_bus_pkg::addr_t offset;
    logic [WORD_W-1:0]    word;

    assign offset = req.addr - lsdom_map_pkg::lpmem_base;
    assign word   = offset[WORD_W+1:2];   // Byte offset to word index

    always_ff @(posedge seq) begin
        if (sel) begin
            if (req.wr) begin
                for (int b = 0; b < lsdom_bus_pkg::STRB_WIDTH; b++) begin
                    if (req.strb[b]) begin
                        mem[word][8*b +: 8] <= req.data[8*b +: 8];
                    end
                end
                rsp.data <= '0;   // Writes return no data
            end else begin
                rsp.data <= mem[word];
            end
            rsp.resp <= lsdom_bus_pkg::resp_okay;
        end
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= sel;   // Fixed one-cycle latency
        end
    end

endmodule

/* lsdom_decoder.sv */
`timescale 1ns/1ps

module lsdom_decoder #(
    parameter int  NUM_MSTS = 3,
    localparam int IDX_W    = (NUM_MSTS > 1) ? $clog2(NUM_MSTS) : 1
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    gnt_valid,
    input  logic [IDX_W-1:0]        gnt_idx,
    input  lsdom_bus_pkg::bus_req_t gnt_req,
    input  logic                    mem_done,
    input  lsdom_bus_pkg::bus_rsp_t mem_rsp,
    input  logic                    cfg_done,
    input  lsdom_bus_pkg::bus_rsp_t cfg_rsp,
    input  logic                    hsdom_done,
    input  lsdom_bus_pkg::bus_rsp_t hsdom_rsp,
    output logic                    mem_sel,
    output logic                    cfg_sel,
    output logic                    hsdom_sel,
    output lsdom_bus_pkg::bus_req_t slv_req,
    output logic                    bus_done,
    output logic [NUM_MSTS-1:0]     mst_done,
    output lsdom_bus_pkg::bus_rsp_t mst_rsp
);

    lsdom_map_pkg::slave_sel_e cur_sel;
    logic                      issued;   // Select already sent for this grant
    logic                      start;
    logic                      err_done;
    logic                      slv_done;

    function automatic lsdom_map_pkg::slave_sel_e decode(lsdom_bus_pkg::addr_t addr);
        if (addr >= lsdom_map_pkg::hsdom_boundary) begin
            return lsdom_map_pkg::sel_hsdom;
        end
        // Unsigned wrap rejects addresses below the base
        if (addr - lsdom_map_pkg::lpmem_base < lsdom_map_pkg::lpmem_size) begin
            return lsdom_map_pkg::sel_lpmem;
        end
        if (addr - lsdom_map_pkg::syscfg_base < lsdom_map_pkg::syscfg_size) begin
            return lsdom_map_pkg::sel_syscfg;
        end
        return lsdom_map_pkg::sel_none;
    endfunction

    assign cur_sel = decode(gnt_req.addr);
    assign start   = gnt_valid && !issued;
    assign slv_req = gnt_req;   // Full address to every slave

    assign mem_sel   = start && (cur_sel == lsdom_map_pkg::sel_lpmem);
    assign cfg_sel   = start && (cur_sel == lsdom_map_pkg::sel_syscfg);
    assign hsdom_sel = start && (cur_sel == lsdom_map_pkg::sel_hsdom);

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            issued   <= 1'b0;
            err_done <= 1'b0;
        end else begin
            err_done <= start && (cur_sel == lsdom_map_pkg::sel_none);
            if (bus_done) begin
                issued <= 1'b0;
            end else if (start) begin
                issued <= 1'b1;
            end
        end
    end

    always_comb begin
        slv_done = 1'b0;
        mst_rsp  = '0;
        unique case (cur_sel)
            lsdom_map_pkg::sel_lpmem: begin
                slv_done = mem_done;
                mst_rsp  = mem_rsp;
            end
            lsdom_map_pkg::sel_syscfg: begin
                slv_done = cfg_done;
                mst_rsp  = cfg_rsp;
            end
            lsdom_map_pkg::sel_hsdom: begin
                slv_done = hsdom_done;
                mst_rsp  = hsdom_rsp;
            end
            default: begin
                slv_done     = err_done;
                mst_rsp.data = '0;   // Decode error reads zero
                mst_rsp.resp = lsdom_bus_pkg::resp_decerr;
            end
        endcase
    end

    assign bus_done = gnt_valid && issued && slv_done;

    // Steer done to the owner
    always_comb begin
        for (int m = 0; m < NUM_MSTS; m++) begin
            mst_done[m] = bus_done && (gnt_idx == IDX_W'(m));
        end
    end

endmodule

/* lsdom_arbiter.sv */
`timescale 1ns/1ps

module lsdom_arbiter #(
    parameter int  NUM_MSTS = 3,
    localparam int IDX_W    = (NUM_MSTS > 1) ? $clog2(NUM_MSTS) : 1
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    pause,
    input  logic [NUM_MSTS-1:0]     mst_req,
    input  lsdom_bus_pkg::bus_req_t mst_req_data [NUM_MSTS],
    input  logic                    bus_done,
    output logic                    gnt_valid,
    output logic [IDX_W-1:0]        gnt_idx,
    output lsdom_bus_pkg::bus_req_t gnt_req
);

    logic [IDX_W-1:0] rr_ptr;   // First candidate of the next search
    logic [IDX_W-1:0] win_idx;
    logic             win_found;
    logic             take;

    // Circular search starting at the pointer
    always_comb begin
        int cand;
        win_found = 1'b0;
        win_idx   = '0;
        for (int k = 0; k < NUM_MSTS; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_MSTS;
            if (!win_found && mst_req[cand]) begin
                win_found = 1'b1;
                win_idx   = IDX_W'(cand);
            end
        end
    end

    assign take = !gnt_valid && !pause && win_found;   // Bus idle only

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            gnt_valid <= 1'b0;
            gnt_idx   <= '0;
            rr_ptr    <= '0;   // Master 0 wins first
        end else if (take) begin
            gnt_valid <= 1'b1;
            gnt_idx   <= win_idx;
            if (win_idx == IDX_W'(NUM_MSTS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= win_idx + 1'b1;
            end
        end else if (bus_done) begin
            gnt_valid <= 1'b0;   // Released the edge after done
        end
    end

    // Winner's request is frozen for the whole access
    always_ff @(posedge seq) begin
        if (take) begin
            gnt_req <= mst_req_data[win_idx];
        end
    end

endmodule

/* lsdom_map_pkg.sv */
package lsdom_map_pkg;

    // Low-power memory of 4 KiB
    localparam lsdom_bus_pkg::addr_t lpmem_base = 32'h0000_0000;
    localparam lsdom_bus_pkg::addr_t lpmem_size = 32'h0000_1000;

    // System configuration registers
    localparam lsdom_bus_pkg::addr_t syscfg_base = 32'h0001_0000;
    localparam lsdom_bus_pkg::addr_t syscfg_size = 32'h0000_0100;

    // Everything from here up belongs to the high-speed domain
    localparam lsdom_bus_pkg::addr_t hsdom_boundary = 32'h8000_0000;

    localparam lsdom_bus_pkg::data_t syscfg_id_value = 32'h4c53_4430;   // "LSD0"

    typedef enum logic [1:0] {
        sel_lpmem  = 2'd0,
        sel_syscfg = 2'd1,
        sel_hsdom  = 2'd2,
        sel_none   = 2'd3
    } slave_sel_e;

endpackage

/* lsdom_bus_pkg.sv */
package lsdom_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;   // Byte address
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;   // One bit per byte lane

    // Encodings follow the AXI response field
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,   // Write to a read-only register
        resp_decerr = 2'b11    // Unmapped address
    } resp_t;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        data_t data;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } bus_rsp_t;

endpackage
